//--- common/mips16_pkg.sv
package mips16_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int WORD_W     = 16;
	localparam int REG_ADDR_W = 3;
	localparam int NUM_REGS   = 8;                // r0 to r7
	localparam int OPC_W      = 5;                // Major opcode in bits 15 to 11
	localparam int IMM_W      = 8;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [OPC_W-1:0]      opcode_t;
	typedef logic [IMM_W-1:0]      imm_t;
	typedef logic [2:0]            alu_op_t;
	typedef logic [2:0]            opnd_mode_t;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	localparam opcode_t OPC_ADDIU = 5'b01001;
	localparam opcode_t OPC_LI    = 5'b01101;
	localparam opcode_t OPC_RRR   = 5'b11100;  // ADDU, SUBU
	localparam opcode_t OPC_RR    = 5'b11101;  // AND, OR
	localparam opcode_t OPC_MOVE  = 5'b01111;
	localparam opcode_t OPC_SHIFT = 5'b00110;  // SLL, SRL, SRA
	localparam opcode_t OPC_NOP   = 5'b00001;

	// Sub-function fields
	localparam logic [1:0] FN_ADDU = 2'b01;    // Bits 1..0
	localparam logic [1:0] FN_SUBU = 2'b11;
	localparam logic [4:0] FN_AND  = 5'b01100; // Bits 4..0
	localparam logic [4:0] FN_OR   = 5'b01101;
	localparam logic [4:0] FN_MOVE = 5'b00000;
	localparam logic [1:0] FN_SLL  = 2'b00;    // Bits 1..0
	localparam logic [1:0] FN_SRL  = 2'b10;
	localparam logic [1:0] FN_SRA  = 2'b11;

	localparam alu_op_t ALU_ADD  = 3'd0;
	localparam alu_op_t ALU_SUB  = 3'd1;
	localparam alu_op_t ALU_AND  = 3'd2;
	localparam alu_op_t ALU_OR   = 3'd3;
	localparam alu_op_t ALU_SLL  = 3'd4;
	localparam alu_op_t ALU_SRL  = 3'd5;
	localparam alu_op_t ALU_SRA  = 3'd6;
	localparam alu_op_t ALU_PASS = 3'd7;       // Result is op1

	localparam opnd_mode_t MODE_REG_REG  = 3'd0;
	localparam opnd_mode_t MODE_REG_SIMM = 3'd1;
	localparam opnd_mode_t MODE_ZIMM     = 3'd2;
	localparam opnd_mode_t MODE_MOVE     = 3'd3;
	localparam opnd_mode_t MODE_SHIFT    = 3'd4;

	////////////////////////////////////////////////////////////
	// Pipeline packets
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       valid;
		alu_op_t    alu_op;
		opnd_mode_t mode;
		reg_addr_t  rd;
		reg_addr_t  rs1;       // rx field
		reg_addr_t  rs2;       // ry field
		imm_t       low_byte;  // Immediate and shift amount source
	} dec_pkt_t;

	typedef struct packed {
		logic      valid;
		alu_op_t   alu_op;
		reg_addr_t rd;
		word_t     op1;
		word_t     op2;
	} ex_pkt_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t addr;
		word_t     data;
	} wb_pkt_t;

endpackage

//--- decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  logic                 clk,
	input  logic                 reset,
	input  mips16_pkg::word_t    instr,
	input  logic                 instr_valid,
	output mips16_pkg::dec_pkt_t dec
);
	import mips16_pkg::*;

	dec_pkt_t dec_next;
	logic     supported;  // Opcode is one the datapath executes

	////////////////////////////////////////////////////////////
	// Classification
	////////////////////////////////////////////////////////////

	always_comb begin
		supported         = 1'b0;
		dec_next.alu_op   = ALU_PASS;
		dec_next.mode     = MODE_ZIMM;
		dec_next.rd       = instr[10:8];  // rx by default
		dec_next.rs1      = instr[10:8];
		dec_next.rs2      = instr[7:5];
		dec_next.low_byte = instr[7:0];

		case (opcode_t'(instr[15:11]))
			OPC_ADDIU: begin
				supported       = 1'b1;
				dec_next.alu_op = ALU_ADD;
				dec_next.mode   = MODE_REG_SIMM;
			end
			OPC_LI: begin
				supported       = 1'b1;
				dec_next.alu_op = ALU_PASS;
				dec_next.mode   = MODE_ZIMM;
			end
			OPC_RRR: begin
				dec_next.mode = MODE_REG_REG;
				dec_next.rd   = instr[4:2];  // Three-register forms write rz
				if (instr[1:0] == FN_ADDU) begin
					supported       = 1'b1;
					dec_next.alu_op = ALU_ADD;
				end else if (instr[1:0] == FN_SUBU) begin
					supported       = 1'b1;
					dec_next.alu_op = ALU_SUB;
				end
			end
			OPC_RR: begin
				dec_next.mode = MODE_REG_REG;
				if (instr[4:0] == FN_AND) begin
					supported       = 1'b1;
					dec_next.alu_op = ALU_AND;
				end else if (instr[4:0] == FN_OR) begin
					supported       = 1'b1;
					dec_next.alu_op = ALU_OR;
				end
			end
			OPC_MOVE: begin
				dec_next.mode = MODE_MOVE;
				if (instr[4:0] == FN_MOVE) begin
					supported       = 1'b1;
					dec_next.alu_op = ALU_PASS;
				end
			end
			OPC_SHIFT: begin
				supported     = 1'b1;
				dec_next.mode = MODE_SHIFT;
				case (instr[1:0])
					FN_SLL:  dec_next.alu_op = ALU_SLL;
					FN_SRL:  dec_next.alu_op = ALU_SRL;
					FN_SRA:  dec_next.alu_op = ALU_SRA;
					default: supported = 1'b0;  // 01 is not a shift
				endcase
			end
			OPC_NOP: begin
				supported = 1'b0;  // Nothing to write back
			end
			default: begin
				supported = 1'b0;
			end
		endcase

		dec_next.valid = instr_valid && supported;
	end

	////////////////////////////////////////////////////////////
	// Decode register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		dec <= dec_next;
		if (reset) begin
			dec.valid <= 1'b0;
		end
	end

endmodule

//--- decode/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                  clk,
	input  logic                  reset,
	input  mips16_pkg::reg_addr_t rs1,
	input  mips16_pkg::reg_addr_t rs2,
	output mips16_pkg::word_t     rdata1,
	output mips16_pkg::word_t     rdata2,
	input  mips16_pkg::wb_pkt_t   wb
);
	import mips16_pkg::*;

	word_t regs [NUM_REGS];

	// Asynchronous read with bypass of the write in flight
	function automatic word_t read_port(input reg_addr_t addr);
		word_t value;
		value = regs[addr];
		if (wb.valid && (wb.addr == addr)) begin
			value = wb.data;  // Write-through
		end
		return value;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.addr] <= wb.data;
		end
	end

	always_comb begin
		rdata1 = read_port(rs1);
	end

	always_comb begin
		rdata2 = read_port(rs2);
	end

endmodule

//--- verilog/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 hold,
	input  mips16_pkg::dec_pkt_t dec,
	input  mips16_pkg::word_t    rdata1,
	input  mips16_pkg::word_t    rdata2,
	input  mips16_pkg::wb_pkt_t  fwd,
	output mips16_pkg::ex_pkt_t  ex
);
	import mips16_pkg::*;

	word_t   val1;     // Read value 1 after forwarding
	word_t   val2;     // Read value 2 after forwarding
	word_t   simm;
	word_t   zimm;
	word_t   shamt;
	logic    issue;    // Instruction goes on to the ALU
	ex_pkt_t ex_next;

	////////////////////////////////////////////////////////////
	// Forwarding from the ALU result
	////////////////////////////////////////////////////////////

	// The instruction one ahead has not reached the register file yet
	function automatic word_t bypass(input reg_addr_t src, input word_t rdata);
		word_t value;
		value = rdata;
		if (fwd.valid && (fwd.addr == src)) begin
			value = fwd.data;
		end
		return value;
	endfunction

	always_comb begin
		val1 = bypass(dec.rs1, rdata1);
		val2 = bypass(dec.rs2, rdata2);
	end

	////////////////////////////////////////////////////////////
	// Immediates
	////////////////////////////////////////////////////////////

	assign simm = {{(WORD_W-IMM_W){dec.low_byte[IMM_W-1]}}, dec.low_byte};
	assign zimm = {{(WORD_W-IMM_W){1'b0}}, dec.low_byte};

	// Shift field of zero encodes a shift by 8
	always_comb begin
		if (dec.low_byte[4:2] == 3'b000) begin
			shamt = word_t'(8);
		end else begin
			shamt = word_t'(dec.low_byte[4:2]);
		end
	end

	////////////////////////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////////////////////////

	assign issue = dec.valid && !hold;  // Hold flushes the decode register

	always_comb begin
		ex_next.valid  = issue;
		ex_next.alu_op = dec.alu_op;
		ex_next.rd     = dec.rd;
		ex_next.op1    = '0;  // Bubble operands
		ex_next.op2    = '0;
		if (issue) begin
			case (dec.mode)
				MODE_REG_REG: begin
					ex_next.op1 = val1;
					ex_next.op2 = val2;
				end
				MODE_REG_SIMM: begin
					ex_next.op1 = val1;
					ex_next.op2 = simm;
				end
				MODE_ZIMM:  ex_next.op1 = zimm;
				MODE_MOVE:  ex_next.op1 = val2;
				MODE_SHIFT: begin
					ex_next.op1 = val2;  // Shifts read ry
					ex_next.op2 = shamt;
				end
				default: ex_next.valid = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		ex <= ex_next;
		if (reset) begin
			ex.valid <= 1'b0;
		end
	end

	// A held cycle must leave a bubble behind it
	a_hold_bubble: assert property (@(posedge clk) disable iff (reset) hold |=> !ex.valid)
		else $error("operand_stage issued an instruction under hold");

endmodule

//--- verilog/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
	input  logic                clk,
	input  logic                reset,
	input  mips16_pkg::ex_pkt_t ex,
	output mips16_pkg::wb_pkt_t fwd,
	output mips16_pkg::wb_pkt_t wb
);
	import mips16_pkg::*;

	word_t      result;
	logic [3:0] shift_by;  // Up to 8 from the operand stage

	assign shift_by = ex.op2[3:0];

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	always_comb begin
		case (ex.alu_op)
			ALU_ADD:  result = ex.op1 + ex.op2;  // Wraps at 16 bits
			ALU_SUB:  result = ex.op1 - ex.op2;
			ALU_AND:  result = ex.op1 & ex.op2;
			ALU_OR:   result = ex.op1 | ex.op2;
			ALU_SLL:  result = ex.op1 << shift_by;
			ALU_SRL:  result = ex.op1 >> shift_by;
			ALU_SRA:  result = word_t'($signed(ex.op1) >>> shift_by);  // Sign fill
			ALU_PASS: result = ex.op1;
			default:  result = ex.op1;
		endcase
	end

	// Unregistered result for the operand stage bypass
	assign fwd = '{valid: ex.valid, addr: ex.rd, data: result};

	////////////////////////////////////////////////////////////
	// Write-back register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		wb <= fwd;
		if (reset) begin
			wb.valid <= 1'b0;
		end
	end

	// Destination comes from the decoder two stages back
	a_wb_addr_known: assert property (
		@(posedge clk) disable iff (reset) wb.valid |-> !$isunknown(wb.addr)
	) else $error("write-back with unknown register address");

endmodule

//--- verilog/mips16_core.sv
`timescale 1ns/1ps

module mips16_core (
	input  logic                  clk,
	input  logic                  reset,
	input  mips16_pkg::word_t     instr,
	input  logic                  instr_valid,
	input  logic                  hold,
	output logic                  wb_valid,
	output mips16_pkg::reg_addr_t wb_addr,
	output mips16_pkg::word_t     wb_data
);
	import mips16_pkg::*;

	dec_pkt_t dec;     // Decode register
	ex_pkt_t  ex;      // Operand register
	wb_pkt_t  fwd;     // ALU result before the write-back register
	wb_pkt_t  wb;      // Write-back register
	word_t    rdata1;
	word_t    rdata2;

	////////////////////////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////////////////////////

	instr_decoder u_decoder (
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instr_valid (instr_valid),
		.dec         (dec)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.reset  (reset),
		.rs1    (dec.rs1),
		.rs2    (dec.rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wb     (wb)
	);

	operand_stage u_operand (
		.clk    (clk),
		.reset  (reset),
		.hold   (hold),
		.dec    (dec),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.fwd    (fwd),
		.ex     (ex)
	);

	alu_stage u_alu (
		.clk   (clk),
		.reset (reset),
		.ex    (ex),
		.fwd   (fwd),
		.wb    (wb)
	);

	assign wb_valid = wb.valid;
	assign wb_addr  = wb.addr;
	assign wb_data  = wb.data;

endmodule

//--- testbench/mips16_core_tb.sv
`timescale 1ns/1ps

module mips16_core_tb;
	import mips16_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int N_ARITH      = 40;
	localparam int N_LOGIC      = 40;
	localparam int N_CHAIN      = 20;
	localparam int N_HOLD       = 24;
	localparam int N_MIXED      = 300;
	localparam int DRAIN_LIMIT  = 10;
	localparam int TOTAL_STEPS  = 28 + (8 + N_ARITH) + (4 + N_LOGIC) + (12 + N_CHAIN)
		+ N_HOLD + N_MIXED + 2 + DRAIN_LIMIT + 3;

	// Major opcodes, bits 15 to 11
	localparam logic [4:0] OP_ADDIU = 5'b01001;
	localparam logic [4:0] OP_LI    = 5'b01101;
	localparam logic [4:0] OP_RRR   = 5'b11100;
	localparam logic [4:0] OP_RR    = 5'b11101;
	localparam logic [4:0] OP_MOVE  = 5'b01111;
	localparam logic [4:0] OP_SHIFT = 5'b00110;
	localparam logic [4:0] OP_NOP   = 5'b00001;

	typedef word_t [NUM_REGS-1:0] model_regs_t;

	logic        clk;
	logic        reset;
	word_t       instr;
	logic        instr_valid;
	logic        hold;
	logic        wb_valid;
	reg_addr_t   wb_addr;
	word_t       wb_data;

	integer      seed = 16;
	int          errors = 0;
	int          checks = 0;
	string       test_name = "reset";
	model_regs_t model_regs = '0;
	wb_pkt_t     exp_q[$];     // Expected write-backs in issue order
	string       name_q[$];
	word_t       pend_instr = '0;  // Issued last cycle, hold not yet known
	logic        pend_live = 1'b0;
	string       pend_name = "";

	mips16_core uut (
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instr_valid (instr_valid),
		.hold        (hold),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic wb_pkt_t expected_result(input word_t ins, input model_regs_t regs);
		logic [2:0] rx;
		logic [2:0] ry;
		word_t      a;
		word_t      b;
		logic [3:0] sa;
		wb_pkt_t    res;
		rx        = ins[10:8];
		ry        = ins[7:5];
		a         = regs[rx];
		b         = regs[ry];
		sa        = (ins[4:2] == 3'd0) ? 4'd8 : {1'b0, ins[4:2]};  // Field 0 shifts by 8
		res.valid = 1'b0;
		res.addr  = rx;
		res.data  = '0;
		case (ins[15:11])
			OP_ADDIU: begin
				res.valid = 1'b1;
				res.data  = a + {{8{ins[7]}}, ins[7:0]};
			end
			OP_LI: begin
				res.valid = 1'b1;
				res.data  = {8'h00, ins[7:0]};
			end
			OP_RRR: begin
				res.addr  = ins[4:2];  // Writes rz
				res.valid = ins[0];    // 01 ADDU, 11 SUBU
				res.data  = ins[1] ? a - b : a + b;
			end
			OP_RR: begin
				res.valid = (ins[4:1] == 4'b0110);
				res.data  = ins[0] ? (a | b) : (a & b);
			end
			OP_MOVE: begin
				res.valid = (ins[4:0] == 5'd0);
				res.data  = b;
			end
			OP_SHIFT: begin
				res.valid = (ins[1:0] != 2'b01);
				case (ins[1:0])
					2'b00:   res.data = b << sa;
					2'b10:   res.data = b >> sa;
					default: res.data = (b >> sa) | (b[15] ? ~(16'hffff >> sa) : 16'h0000);
				endcase
			end
			default: res.valid = 1'b0;
		endcase
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// Instruction builders
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	function automatic word_t encode_imm(input logic [4:0] opc, input logic [2:0] rx,
		input logic [7:0] imm);
		return {opc, rx, imm};
	endfunction

	function automatic word_t encode_reg(input logic [4:0] opc, input logic [2:0] rx,
		input logic [2:0] ry, input logic [4:0] low);
		return {opc, rx, ry, low};
	endfunction

	function automatic word_t arith_instr();
		logic [31:0] r;
		r = next_random();
		case (r[1:0])
			2'd2:    return encode_reg(OP_RRR, r[4:2], r[7:5], {r[10:8], 2'b01});
			2'd3:    return encode_reg(OP_RRR, r[4:2], r[7:5], {r[10:8], 2'b11});
			default: return encode_imm(OP_ADDIU, r[4:2], r[18:11]);  // Either sign
		endcase
	endfunction

	function automatic word_t logic_instr();
		logic [31:0] r;
		r = next_random();
		case (r[2:0])
			3'd0:       return encode_reg(OP_RR, r[5:3], r[8:6], 5'b01100);
			3'd1:       return encode_reg(OP_RR, r[5:3], r[8:6], 5'b01101);
			3'd2, 3'd3: return encode_reg(OP_SHIFT, r[5:3], r[8:6], {r[14:12], 2'b00});
			3'd4, 3'd5: return encode_reg(OP_SHIFT, r[5:3], r[8:6], {r[14:12], 2'b10});
			default:    return encode_reg(OP_SHIFT, r[5:3], r[8:6], {r[14:12], 2'b11});
		endcase
	endfunction

	// Only r1 and r2, so most instructions depend on the one before
	function automatic word_t chained_instr();
		logic [31:0] r;
		logic [2:0]  a;
		logic [2:0]  b;
		logic [2:0]  c;
		r = next_random();
		a = {2'b00, r[2]} + 3'd1;
		b = {2'b00, r[3]} + 3'd1;
		c = {2'b00, r[4]} + 3'd1;
		case (r[1:0])
			2'd0:    return encode_imm(OP_ADDIU, a, r[15:8]);
			2'd1:    return encode_reg(OP_RRR, a, b, {c, 2'b01});
			2'd2:    return encode_reg(OP_RRR, a, b, {c, 2'b11});
			default: return encode_reg(OP_SHIFT, a, b, {r[7:5], 2'b00});
		endcase
	endfunction

	function automatic word_t mixed_instr();
		logic [31:0] r;
		r = next_random();
		case (r[2:0])
			3'd0:       return encode_reg(OP_NOP, 3'd0, 3'd0, 5'd0);
			3'd1:       return r[31:16];  // Any encoding at all
			3'd2:       return encode_reg(OP_RRR, r[10:8], r[13:11], {r[16:14], 2'b10});
			3'd3, 3'd4: return arith_instr();
			3'd5, 3'd6: return logic_instr();
			default: begin
				if (r[8]) begin
					return encode_imm(OP_LI, r[11:9], r[19:12]);
				end
				return encode_reg(OP_MOVE, r[11:9], r[14:12], 5'd0);
			end
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Hold in this cycle decides the fate of last cycle's instruction
	task automatic issue(input word_t ins, input logic valid, input logic hold_now);
		wb_pkt_t e;
		@(negedge clk);
		if (pend_live && !hold_now) begin
			e = expected_result(pend_instr, model_regs);
			if (e.valid) begin
				model_regs[e.addr] = e.data;
				exp_q.push_back(e);
				name_q.push_back(pend_name);
			end
		end
		instr       = ins;
		instr_valid = valid;
		hold        = hold_now;
		pend_instr  = ins;
		pend_live   = valid;
		pend_name   = test_name;
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	initial begin
		logic [31:0] r;
		int          waited;
		reset       = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		hold        = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_name = "reset_li_move";
		repeat (4) issue('0, 1'b0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			issue(encode_reg(OP_MOVE, 3'(i), 3'(i), 5'd0), 1'b1, 1'b0);  // Reset value
		end
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			issue(encode_imm(OP_LI, 3'(i), r[7:0]), 1'b1, 1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			issue(encode_reg(OP_MOVE, 3'(i), 3'(i), 5'd0), 1'b1, 1'b0);  // Reads the file
		end

		test_name = "arith";
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			issue(encode_imm(OP_LI, 3'(i), r[7:0]), 1'b1, 1'b0);
		end
		repeat (N_ARITH) issue(arith_instr(), 1'b1, 1'b0);

		test_name = "logic_shift";
		issue(encode_imm(OP_LI, 3'd1, 8'h9c), 1'b1, 1'b0);
		issue(encode_reg(OP_SHIFT, 3'd2, 3'd1, 5'b000_00), 1'b1, 1'b0);  // SLL by 8
		issue(encode_reg(OP_SHIFT, 3'd3, 3'd2, 5'b000_11), 1'b1, 1'b0);  // SRA by 8
		issue(encode_reg(OP_SHIFT, 3'd4, 3'd2, 5'b011_10), 1'b1, 1'b0);
		repeat (N_LOGIC) issue(logic_instr(), 1'b1, 1'b0);

		test_name = "dependent";
		repeat (6) issue(encode_imm(OP_ADDIU, 3'd5, 8'h01), 1'b1, 1'b0);  // Distance 1
		for (int i = 0; i < 6; i++) begin
			issue(encode_imm(OP_ADDIU, (i % 2 == 0) ? 3'd5 : 3'd6, 8'hfe), 1'b1, 1'b0);
		end
		repeat (N_CHAIN) issue(chained_instr(), 1'b1, 1'b0);

		test_name = "hold";
		for (int i = 0; i < N_HOLD; i++) begin
			issue(arith_instr(), 1'b1, (i % 6 == 2) || (i % 6 == 3));
		end

		test_name = "mixed";
		for (int i = 0; i < N_MIXED; i++) begin
			r = next_random();
			issue(mixed_instr(), r[3:0] != 4'd0, 1'b0);
		end

		test_name = "drain";
		repeat (2) issue('0, 1'b0, 1'b0);
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		repeat (3) @(posedge clk);  // Room for a stray pulse to show up
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected write-backs never appeared", exp_q.size());
		end

		$display("Errors: %0d in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Compare and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		wb_pkt_t e;
		string   name;
		forever begin
			@(negedge clk);
			if ($isunknown(wb_valid)) begin
				errors++;
				$display("wb_valid is unknown at %0t", $time);
			end else if (wb_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Write-back to r%0d with data %h when none was expected",
						wb_addr, wb_data);
				end else begin
					e    = exp_q.pop_front();
					name = name_q.pop_front();
					check_value({name, " addr"}, {13'd0, e.addr}, {13'd0, wb_addr});
					check_value({name, " data"}, e.data, wb_data);
				end
			end
		end
	end

	initial begin
		repeat (RESET_CYCLES + TOTAL_STEPS * 3 + 20) @(posedge clk);
		$display("Timeout: the run did not finish in time, %0d errors so far", errors);
		$display("sim failed");
		$finish;
	end

endmodule

//--- mips16_core.f
common/mips16_pkg.sv
decode/instr_decoder.sv
decode/reg_file.sv
verilog/operand_stage.sv
verilog/alu_stage.sv
verilog/mips16_core.sv
testbench/mips16_core_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = mips16_core_tb
FILELIST   = mips16_core.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
